/* hdl/gbuf_pkg.sv */
/*
  Shared sizes, stream codes and bus structs of the global buffer host link.
  Stream codes keep the host link encoding, so the host side must decode the same values.
  BANK_AW must give a power-of-two depth. Banks use the top level bit as full.
*/
`default_nettype none

package gbuf_pkg;

    //====================================================================
    // Sizes
    //====================================================================
    localparam int DATA_W        = 16;
    localparam int BANK_AW       = 6;
    localparam int BANK_DEPTH    = 1 << BANK_AW;
    localparam int NUM_BANKS     = 6;
    localparam int NUM_IN_BANKS  = 4;
    localparam int NUM_OUT_BANKS = 2;
    localparam int OUT_IDX_W     = $clog2(NUM_OUT_BANKS);

    // Transfer lengths in words
    localparam int BURST_LEN = 8;
    localparam int CFG_LEN   = 4;
    localparam int CNT_W     = $clog2(BURST_LEN);

    //====================================================================
    // Stream codes and structs
    //====================================================================
    typedef enum logic [3:0] {
        SEL_CFG    = 4'd0,
        SEL_ACT    = 4'd2,
        SEL_FLGACT = 4'd4,
        SEL_WEI    = 4'd6,
        SEL_FLGWEI = 4'd8,
        SEL_FLGOFM = 4'd10,
        SEL_OFM    = 4'd11
    } link_sel_e;

    typedef struct packed {
        logic              en;
        logic [DATA_W-1:0] data;
    } bank_wr_t;

    typedef struct packed {
        logic en;
    } bank_rd_t;

    typedef struct packed {
        logic [BANK_AW:0] level;
    } bank_stat_t;

    typedef struct packed {
        logic      active;
        link_sel_e sel;
        logic      upload;
    } link_grant_t;

    // One-hot bank mask of a stream code, empty for config
    function automatic logic [NUM_BANKS-1:0] sel_onehot(input link_sel_e sel);
        logic [NUM_BANKS-1:0] oh;
        oh = '0;
        case (sel)
            SEL_FLGWEI: oh[0] = 1'b1;
            SEL_WEI:    oh[1] = 1'b1;
            SEL_FLGACT: oh[2] = 1'b1;
            SEL_ACT:    oh[3] = 1'b1;
            SEL_FLGOFM: oh[4] = 1'b1;
            SEL_OFM:    oh[5] = 1'b1;
            default:    oh = '0;
        endcase
        return oh;
    endfunction

    // Stream code that serves a bank index
    function automatic link_sel_e bank_sel(input int idx);
        link_sel_e sel;
        case (idx)
            0:       sel = SEL_FLGWEI;
            1:       sel = SEL_WEI;
            2:       sel = SEL_FLGACT;
            3:       sel = SEL_ACT;
            4:       sel = SEL_FLGOFM;
            5:       sel = SEL_OFM;
            default: sel = SEL_CFG;
        endcase
        return sel;
    endfunction

endpackage

`default_nettype wire

/* hdl/gbuf_bank.sv */
/*
  One circular buffer bank of BANK_DEPTH words.
  Writes when full and reads when empty are dropped without notice.
  Read data arrives one cycle after an accepted read, with rd_valid.
*/
`timescale 1ns/10ps
`default_nettype none

module gbuf_bank (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      clear,
    input  gbuf_pkg::bank_wr_t             wr,
    input  gbuf_pkg::bank_rd_t             rd,
    output logic [gbuf_pkg::DATA_W-1:0]    rd_data,
    output logic                           rd_valid,
    output gbuf_pkg::bank_stat_t           stat
);
    import gbuf_pkg::*;

    logic [DATA_W-1:0]  mem [BANK_DEPTH];
    logic [BANK_AW-1:0] wr_ptr;
    logic [BANK_AW-1:0] rd_ptr;
    logic [BANK_AW:0]   count;
    logic               full;
    logic               empty;
    logic               wr_ok;
    logic               rd_ok;

    // Depth is a power of two, so the top count bit means full
    assign full  = count[BANK_AW];
    assign empty = (count == '0);
    assign wr_ok = wr.en & ~full;
    assign rd_ok = rd.en & ~empty;

    assign stat.level = count;

    //====================================================================
    // Pointers and level
    //====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else if (clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr.data;
        end
        if (rd_ok) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* hdl/link_scheduler.sv */
/*
  Picks the next host link transfer and counts its words.
  A grant is issued one cycle after the scheduler goes idle, never back to back.
  The host must send exactly CFG_LEN or BURST_LEN strobed words per inbound grant.
*/
`timescale 1ns/10ps
`default_nettype none

module link_scheduler (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  clear,
    input  wire logic                  cfg_req,
    input  gbuf_pkg::bank_stat_t       level [gbuf_pkg::NUM_BANKS],
    input  wire logic                  link_in_valid,
    input  wire logic                  upload_step,
    output gbuf_pkg::link_grant_t      grant,
    output logic                       link_req,
    output logic                       link_done
);
    import gbuf_pkg::*;

    logic             cfg_pend;
    logic [CNT_W-1:0] word_cnt;
    logic             step;
    logic             last_word;
    logic             pick_valid;
    link_sel_e        pick_sel;
    logic             pick_upload;

    //====================================================================
    // Priority pick
    //====================================================================
    // Lowest priority first, later hits override earlier ones
    always_comb begin
        pick_valid  = 1'b0;
        pick_sel    = SEL_CFG;
        pick_upload = 1'b0;
        // Input banks need room for a whole burst
        for (int i = NUM_IN_BANKS - 1; i >= 0; i--) begin
            if (int'(level[i].level) <= BANK_DEPTH - BURST_LEN) begin
                pick_valid  = 1'b1;
                pick_sel    = bank_sel(i);
                pick_upload = 1'b0;
            end
        end
        // Output banks need a whole burst stored
        for (int i = NUM_BANKS - 1; i >= NUM_IN_BANKS; i--) begin
            if (int'(level[i].level) >= BURST_LEN) begin
                pick_valid  = 1'b1;
                pick_sel    = bank_sel(i);
                pick_upload = 1'b1;
            end
        end
        if (cfg_pend) begin
            pick_valid  = 1'b1;
            pick_sel    = SEL_CFG;
            pick_upload = 1'b0;
        end
    end

    //====================================================================
    // Word counting
    //====================================================================
    assign step      = grant.upload ? upload_step : link_in_valid;
    assign last_word = (grant.sel == SEL_CFG) ? (word_cnt == CNT_W'(CFG_LEN - 1))
                                              : (word_cnt == CNT_W'(BURST_LEN - 1));
    assign link_done = grant.active & step & last_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant    <= '{active: 1'b0, sel: SEL_CFG, upload: 1'b0};
            link_req <= 1'b0;
            word_cnt <= '0;
            cfg_pend <= 1'b0;
        end else if (clear) begin
            grant    <= '{active: 1'b0, sel: SEL_CFG, upload: 1'b0};
            link_req <= 1'b0;
            word_cnt <= '0;
            cfg_pend <= 1'b0;
        end else begin
            link_req <= 1'b0;
            if (!grant.active) begin
                word_cnt <= '0;
                if (pick_valid) begin
                    grant.active <= 1'b1;
                    grant.sel    <= pick_sel;
                    grant.upload <= pick_upload;
                    link_req     <= 1'b1;
                end
            end else if (step) begin
                if (last_word) begin
                    grant.active <= 1'b0;
                    word_cnt     <= '0;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end

            // Config request stays pending until its grant
            if (cfg_req) begin
                cfg_pend <= 1'b1;
            end else if (!grant.active && pick_valid && pick_sel == SEL_CFG) begin
                cfg_pend <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/link_demux.sv */
/*
  Steers inbound link words to the config port or an input bank.
  Output banks are written by the core only. Purely combinational.
*/
`timescale 1ns/10ps
`default_nettype none

module link_demux (
    input  gbuf_pkg::link_grant_t          grant,
    input  wire logic                      link_in_valid,
    input  wire logic [gbuf_pkg::DATA_W-1:0] link_in_data,
    input  wire logic [gbuf_pkg::NUM_OUT_BANKS-1:0] core_wr,
    input  wire logic [gbuf_pkg::DATA_W-1:0] core_wr_data [gbuf_pkg::NUM_OUT_BANKS],
    output gbuf_pkg::bank_wr_t             bank_wr [gbuf_pkg::NUM_BANKS],
    output logic                           cfg_valid,
    output logic [gbuf_pkg::DATA_W-1:0]    cfg_word
);
    import gbuf_pkg::*;

    logic                 inbound;
    logic                 is_cfg;
    logic [NUM_BANKS-1:0] sel_oh;

    // Strobed word of an active inbound transfer
    assign inbound = grant.active & ~grant.upload & link_in_valid;
    assign is_cfg  = (grant.sel == SEL_CFG);
    assign sel_oh  = sel_onehot(grant.sel);

    assign cfg_valid = inbound & is_cfg;
    assign cfg_word  = is_cfg ? link_in_data : '0;

    //====================================================================
    // Bank write structs
    //====================================================================
    always_comb begin
        for (int i = 0; i < NUM_IN_BANKS; i++) begin
            bank_wr[i].en   = inbound & sel_oh[i];
            bank_wr[i].data = link_in_data;
        end
        // Output maps come from the core
        for (int j = 0; j < NUM_OUT_BANKS; j++) begin
            bank_wr[NUM_IN_BANKS + j].en   = core_wr[j];
            bank_wr[NUM_IN_BANKS + j].data = core_wr_data[j];
        end
    end

endmodule

`default_nettype wire

/* hdl/link_upload.sv */
/*
  Reads the granted output bank once per cycle during an upload.
  Assumes the bank holds a full burst at grant time, as the scheduler ensures.
  Core read enables and data of the input banks pass through here too.
*/
`timescale 1ns/10ps
`default_nettype none

module link_upload (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      clear,
    input  gbuf_pkg::link_grant_t          grant,
    input  wire logic [gbuf_pkg::NUM_IN_BANKS-1:0] core_rd,
    input  wire logic [gbuf_pkg::DATA_W-1:0] bank_rd_data [gbuf_pkg::NUM_BANKS],
    input  wire logic [gbuf_pkg::NUM_BANKS-1:0] bank_rd_valid,
    output gbuf_pkg::bank_rd_t             bank_rd [gbuf_pkg::NUM_BANKS],
    output logic                           upload_step,
    output logic                           link_out_valid,
    output logic [gbuf_pkg::DATA_W-1:0]    link_out_data,
    output logic [gbuf_pkg::NUM_IN_BANKS-1:0] core_rd_valid,
    output logic [gbuf_pkg::DATA_W-1:0]    core_rd_data [gbuf_pkg::NUM_IN_BANKS]
);
    import gbuf_pkg::*;

    logic [NUM_BANKS-1:0] grant_oh;
    logic [OUT_IDX_W-1:0] grant_idx;
    logic [OUT_IDX_W-1:0] ret_idx;

    assign grant_oh    = sel_onehot(grant.sel);
    assign upload_step = grant.active & grant.upload;

    // Output bank index of the current grant
    always_comb begin
        grant_idx = '0;
        for (int j = 0; j < NUM_OUT_BANKS; j++) begin
            if (grant_oh[NUM_IN_BANKS + j]) begin
                grant_idx = OUT_IDX_W'(j);
            end
        end
    end

    //====================================================================
    // Read enables
    //====================================================================
    always_comb begin
        for (int i = 0; i < NUM_IN_BANKS; i++) begin
            bank_rd[i].en = core_rd[i];
        end
        for (int j = 0; j < NUM_OUT_BANKS; j++) begin
            bank_rd[NUM_IN_BANKS + j].en = upload_step & grant_oh[NUM_IN_BANKS + j];
        end
    end

    // Bank whose data returns next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ret_idx <= '0;
        end else if (clear) begin
            ret_idx <= '0;
        end else if (upload_step) begin
            ret_idx <= grant_idx;
        end
    end

    //====================================================================
    // Return data
    //====================================================================
    assign link_out_valid = bank_rd_valid[NUM_IN_BANKS + ret_idx];
    assign link_out_data  = bank_rd_data[NUM_IN_BANKS + ret_idx];

    always_comb begin
        for (int i = 0; i < NUM_IN_BANKS; i++) begin
            core_rd_valid[i] = bank_rd_valid[i];
            core_rd_data[i]  = bank_rd_data[i];
        end
    end

endmodule

`default_nettype wire

/* hdl/gbuf_link_top.sv */
/*
  Host link front end of the global buffer, everything on clk.
  No back-pressure on the link, and the core side is not flow controlled.
  Banks 0 to 3 are filled by the host, banks 4 and 5 by the core.
*/
`timescale 1ns/10ps
`default_nettype none

module gbuf_link_top (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          clear,
    input  wire logic                          cfg_req,
    output logic                               link_req,
    output gbuf_pkg::link_sel_e                link_sel,
    output logic                               link_upload,
    output logic                               link_done,
    input  wire logic                          link_in_valid,
    input  wire logic [gbuf_pkg::DATA_W-1:0]   link_in_data,
    output logic                               link_out_valid,
    output logic [gbuf_pkg::DATA_W-1:0]        link_out_data,
    output logic                               cfg_valid,
    output logic [gbuf_pkg::DATA_W-1:0]        cfg_word,
    input  wire logic [gbuf_pkg::NUM_IN_BANKS-1:0] core_rd,
    output logic [gbuf_pkg::NUM_IN_BANKS-1:0]  core_rd_valid,
    output logic [gbuf_pkg::DATA_W-1:0]        core_rd_data [gbuf_pkg::NUM_IN_BANKS],
    input  wire logic [gbuf_pkg::NUM_OUT_BANKS-1:0] core_wr,
    input  wire logic [gbuf_pkg::DATA_W-1:0]   core_wr_data [gbuf_pkg::NUM_OUT_BANKS],
    output gbuf_pkg::bank_stat_t               level [gbuf_pkg::NUM_BANKS]
);
    import gbuf_pkg::*;

    link_grant_t          grant;
    logic                 upload_step;
    bank_wr_t             bank_wr [NUM_BANKS];
    bank_rd_t             bank_rd [NUM_BANKS];
    logic [DATA_W-1:0]    bank_rd_data [NUM_BANKS];
    logic [NUM_BANKS-1:0] bank_rd_valid;

    // Stream code and direction go out to the host
    assign link_sel    = grant.sel;
    assign link_upload = grant.upload;

    //====================================================================
    // Control
    //====================================================================
    link_scheduler u_scheduler (
        .clk           (clk),
        .rst_n         (rst_n),
        .clear         (clear),
        .cfg_req       (cfg_req),
        .level         (level),
        .link_in_valid (link_in_valid),
        .upload_step   (upload_step),
        .grant         (grant),
        .link_req      (link_req),
        .link_done     (link_done)
    );

    link_demux u_demux (
        .grant         (grant),
        .link_in_valid (link_in_valid),
        .link_in_data  (link_in_data),
        .core_wr       (core_wr),
        .core_wr_data  (core_wr_data),
        .bank_wr       (bank_wr),
        .cfg_valid     (cfg_valid),
        .cfg_word      (cfg_word)
    );

    link_upload u_upload (
        .clk            (clk),
        .rst_n          (rst_n),
        .clear          (clear),
        .grant          (grant),
        .core_rd        (core_rd),
        .bank_rd_data   (bank_rd_data),
        .bank_rd_valid  (bank_rd_valid),
        .bank_rd        (bank_rd),
        .upload_step    (upload_step),
        .link_out_valid (link_out_valid),
        .link_out_data  (link_out_data),
        .core_rd_valid  (core_rd_valid),
        .core_rd_data   (core_rd_data)
    );

    //====================================================================
    // Buffer banks
    //====================================================================
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        gbuf_bank u_bank (
            .clk      (clk),
            .rst_n    (rst_n),
            .clear    (clear),
            .wr       (bank_wr[b]),
            .rd       (bank_rd[b]),
            .rd_data  (bank_rd_data[b]),
            .rd_valid (bank_rd_valid[b]),
            .stat     (level[b])
        );
    end

endmodule

`default_nettype wire

/* bench/tb_gbuf_link.sv */
/*
  Testbench for the global buffer host link, playing both the host and the core.
  A queue per bank and a grant predictor model the DUT; outputs are sampled on the falling edge.
  Inputs change only on the rising edge, and the first mismatch ends the run.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_gbuf_link;
    import gbuf_pkg::*;

    localparam int N_TRANSFERS = 3 + 20 + 24 + 6 + 16;
    localparam int MAX_CYCLES  = N_TRANSFERS * BURST_LEN * 6 + 100;
    localparam link_sel_e BANK_CODE [NUM_BANKS] = '{SEL_FLGWEI, SEL_WEI, SEL_FLGACT,
                                                     SEL_ACT, SEL_FLGOFM, SEL_OFM};

    logic                     clk;
    logic                     rst_n;
    logic                     clear;
    logic                     cfg_req;
    logic                     link_req;
    link_sel_e                link_sel;
    logic                     link_upload;
    logic                     link_done;
    logic                     link_in_valid;
    logic [DATA_W-1:0]        link_in_data;
    logic                     link_out_valid;
    logic [DATA_W-1:0]        link_out_data;
    logic                     cfg_valid;
    logic [DATA_W-1:0]        cfg_word;
    logic [NUM_IN_BANKS-1:0]  core_rd;
    logic [NUM_IN_BANKS-1:0]  core_rd_valid;
    logic [DATA_W-1:0]        core_rd_data [NUM_IN_BANKS];
    logic [NUM_OUT_BANKS-1:0] core_wr;
    logic [DATA_W-1:0]        core_wr_data [NUM_OUT_BANKS];
    bank_stat_t               level [NUM_BANKS];

    // Stimulus control
    logic [31:0] rng;
    logic        core_on;
    logic        wr_on;
    logic        do_cfg;
    logic        do_clear;
    int          host_left;
    int          cycles;

    // Reference model
    logic [DATA_W-1:0]       bank_q [NUM_BANKS][$];
    logic [DATA_W-1:0]       rd_exp [NUM_IN_BANKS];
    logic [NUM_IN_BANKS-1:0] rd_pend;
    logic [DATA_W-1:0]       out_exp;
    logic                    out_pend;
    logic                    busy;
    logic                    up_cur;
    link_sel_e               sel_cur;
    int                      cnt;
    logic                    cfg_pend;
    logic                    want_req;
    link_grant_t             want;
    link_sel_e               last_sel;
    logic                    last_up;
    int                      n_grant;
    int                      n_done;
    int                      n_upload;
    int                      n_cfg_words;

    gbuf_link_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .clear          (clear),
        .cfg_req        (cfg_req),
        .link_req       (link_req),
        .link_sel       (link_sel),
        .link_upload    (link_upload),
        .link_done      (link_done),
        .link_in_valid  (link_in_valid),
        .link_in_data   (link_in_data),
        .link_out_valid (link_out_valid),
        .link_out_data  (link_out_data),
        .cfg_valid      (cfg_valid),
        .cfg_word       (cfg_word),
        .core_rd        (core_rd),
        .core_rd_valid  (core_rd_valid),
        .core_rd_data   (core_rd_data),
        .core_wr        (core_wr),
        .core_wr_data   (core_wr_data),
        .level          (level)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //======================================================================
    // Helpers
    //======================================================================
    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function automatic int code_bank(input link_sel_e sel);
        int idx;
        idx = -1;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (BANK_CODE[b] == sel) begin
                idx = b;
            end
        end
        return idx;
    endfunction

    // Expected next grant from the model levels in fixed priority order
    function automatic link_grant_t next_grant(input logic pending);
        link_grant_t g;
        g = '{active: pending, sel: SEL_CFG, upload: 1'b0};
        for (int b = NUM_IN_BANKS; b < NUM_BANKS; b++) begin
            if (!g.active && bank_q[b].size() >= BURST_LEN) begin
                g = '{active: 1'b1, sel: BANK_CODE[b], upload: 1'b1};
            end
        end
        for (int b = 0; b < NUM_IN_BANKS; b++) begin
            if (!g.active && BANK_DEPTH - bank_q[b].size() >= BURST_LEN) begin
                g = '{active: 1'b1, sel: BANK_CODE[b], upload: 1'b0};
            end
        end
        return g;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("CHECK FAILED at %0t: %s", $time, what));
    endtask

    task automatic wait_transfers(input int n);
        int target;
        @(posedge clk);
        target = n_done + n;
        while (n_done < target) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_grant();
        int target;
        @(posedge clk);
        target = n_grant + 1;
        while (n_grant < target) begin
            @(posedge clk);
        end
    endtask

    //======================================================================
    // Host and core stimulus
    //======================================================================
    always @(negedge clk) begin
        if (rst_n && link_req && !link_upload && !clear) begin
            host_left = (link_sel == SEL_CFG) ? CFG_LEN : BURST_LEN;
        end
    end

    always @(posedge clk) begin
        logic [31:0] r;
        logic [31:0] d;
        if (rst_n) begin
            r = xorshift();
            clear   <= do_clear;
            cfg_req <= do_cfg;
            if (do_clear) begin
                host_left = 0;
            end
            // Burst words with random gaps
            if (host_left > 0 && r[1:0] != 2'b00) begin
                link_in_valid <= 1'b1;
                link_in_data  <= r[31:16];
                host_left--;
            end else begin
                link_in_valid <= 1'b0;
            end
            core_rd <= (core_on && !do_clear) ? (r[7:4] & r[11:8]) : '0;
            for (int j = 0; j < NUM_OUT_BANKS; j++) begin
                d = xorshift();
                core_wr[j]      <= wr_on && !do_clear && d[17:16] == 2'b00;
                core_wr_data[j] <= d[DATA_W-1:0];
            end
            do_clear = 1'b0;
            do_cfg   = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    //======================================================================
    // Checker runs once per cycle on the falling edge
    //======================================================================
    always @(negedge clk) begin
        link_grant_t pick;
        int          bank;
        int          last;
        logic        step;
        int          fill [NUM_BANKS];
        if (rst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                fill[b] = bank_q[b].size();
                assert (int'(level[b].level) == fill[b])
                    else report_mismatch($sformatf("bank %0d level %0d, expected %0d",
                                                   b, level[b].level, fill[b]));
            end
            if (want_req) begin
                assert (link_req && link_sel == want.sel && link_upload == want.upload)
                    else report_mismatch($sformatf("grant %s up %0b, expected %s up %0b",
                                                   link_sel.name(), link_upload,
                                                   want.sel.name(), want.upload));
            end else begin
                assert (!link_req) else report_mismatch("link_req with no stream due");
            end
            // Stream code and direction hold for the whole transfer
            if (busy) begin
                assert (link_sel == sel_cur && link_upload == up_cur)
                    else report_mismatch($sformatf("stream moved to %s up %0b mid transfer",
                                                   link_sel.name(), link_upload));
            end
            if (link_req) begin
                busy     = 1'b1;
                cnt      = 0;
                sel_cur  = link_sel;
                up_cur   = link_upload;
                last_sel = link_sel;
                last_up  = link_upload;
                n_grant++;
                if (link_upload) begin
                    n_upload++;
                end
            end
            pick     = next_grant(cfg_pend);
            want_req = !busy && pick.active && !clear;
            want     = pick;

            // Word count, end of transfer and config port
            step = busy && (up_cur || link_in_valid);
            last = (sel_cur == SEL_CFG) ? CFG_LEN : BURST_LEN;
            bank = code_bank(sel_cur);
            assert (link_done == (step && cnt == last - 1))
                else report_mismatch($sformatf("link_done %0b at word %0d", link_done, cnt));
            assert (cfg_valid == (step && !up_cur && bank < 0))
                else report_mismatch("cfg_valid");
            if (cfg_valid) begin
                assert (cfg_word == link_in_data) else report_mismatch("cfg_word");
                n_cfg_words++;
            end

            // Data of the reads issued one cycle ago
            for (int i = 0; i < NUM_IN_BANKS; i++) begin
                assert (core_rd_valid[i] == rd_pend[i])
                    else report_mismatch($sformatf("core_rd_valid of bank %0d", i));
                if (rd_pend[i]) begin
                    assert (core_rd_data[i] == rd_exp[i])
                        else report_mismatch($sformatf("core read bank %0d got %h, expected %h",
                                                       i, core_rd_data[i], rd_exp[i]));
                end
            end
            assert (link_out_valid == out_pend) else report_mismatch("link_out_valid");
            if (out_pend) begin
                assert (link_out_data == out_exp)
                    else report_mismatch($sformatf("upload word %h, expected %h",
                                                   link_out_data, out_exp));
            end

            // Reads and writes both see the level at the start of the cycle
            rd_pend  = '0;
            out_pend = 1'b0;
            for (int i = 0; i < NUM_IN_BANKS; i++) begin
                if (core_rd[i] && fill[i] > 0) begin
                    rd_exp[i]  = bank_q[i].pop_front();
                    rd_pend[i] = 1'b1;
                end
            end
            if (step && up_cur && fill[bank] > 0) begin
                out_exp  = bank_q[bank].pop_front();
                out_pend = 1'b1;
            end
            if (step && !up_cur && bank >= 0 && fill[bank] < BANK_DEPTH) begin
                bank_q[bank].push_back(link_in_data);
            end
            for (int j = 0; j < NUM_OUT_BANKS; j++) begin
                if (core_wr[j] && fill[NUM_IN_BANKS + j] < BANK_DEPTH) begin
                    bank_q[NUM_IN_BANKS + j].push_back(core_wr_data[j]);
                end
            end
            if (step) begin
                if (link_done) begin
                    busy = 1'b0;
                    cnt  = 0;
                    n_done++;
                end else begin
                    cnt++;
                end
            end
            if (cfg_req) begin
                cfg_pend = 1'b1;
            end else if (want_req && want.sel == SEL_CFG) begin
                cfg_pend = 1'b0;
            end
            // Clear wipes every bank and the scheduler
            if (clear) begin
                for (int b = 0; b < NUM_BANKS; b++) begin
                    bank_q[b].delete();
                end
                busy     = 1'b0;
                cnt      = 0;
                cfg_pend = 1'b0;
                rd_pend  = '0;
                out_pend = 1'b0;
                want_req = 1'b0;
            end
        end
    end

    //======================================================================
    // Test sequence
    //======================================================================
    initial begin
        rst_n         = 1'b0;
        clear         = 1'b0;
        cfg_req       = 1'b0;
        link_in_valid = 1'b0;
        link_in_data  = '0;
        core_rd       = '0;
        core_wr       = '0;
        for (int j = 0; j < NUM_OUT_BANKS; j++) begin
            core_wr_data[j] = '0;
        end
        rng         = 32'd88822;
        core_on     = 1'b0;
        wr_on       = 1'b0;
        do_cfg      = 1'b0;
        do_clear    = 1'b0;
        host_left   = 0;
        cycles      = 0;
        rd_pend     = '0;
        out_pend    = 1'b0;
        busy        = 1'b0;
        up_cur      = 1'b0;
        sel_cur     = SEL_CFG;
        cnt         = 0;
        cfg_pend    = 1'b0;
        want_req    = 1'b0;
        want        = '{active: 1'b0, sel: SEL_CFG, upload: 1'b0};
        n_grant     = 0;
        n_done      = 0;
        n_upload    = 0;
        n_cfg_words = 0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!link_req && !link_done && !link_out_valid && !cfg_valid && core_rd_valid == '0)
            else report_mismatch("outputs not idle after reset");

        // First grant, then a config request during that burst
        wait_grant();
        assert (last_sel == SEL_FLGWEI && !last_up) else report_mismatch("first grant");
        @(negedge clk);
        do_cfg = 1'b1;
        wait_transfers(3);
        assert (n_cfg_words == CFG_LEN) else report_mismatch("config words not seen");

        // Input streaming with core reads, then core writes for uploads
        core_on = 1'b1;
        wait_transfers(20);
        wr_on = 1'b1;
        wait_transfers(24);
        assert (n_upload > 0) else report_mismatch("no upload was granted");

        // Clear during an inbound burst with a config request pending
        wait_grant();
        while (last_up) begin
            wait_grant();
        end
        @(negedge clk);
        do_cfg = 1'b1;
        @(negedge clk);
        do_clear = 1'b1;
        wait_grant();
        assert (last_sel == SEL_FLGWEI && !last_up) else report_mismatch("grant after clear");
        wait_transfers(16);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* gbuf_link_top.f */
hdl/gbuf_pkg.sv
hdl/gbuf_bank.sv
hdl/link_scheduler.sv
hdl/link_demux.sv
hdl/link_upload.sv
hdl/gbuf_link_top.sv
bench/tb_gbuf_link.sv

/* Makefile */
# Verilator build and run of the global buffer host link testbench

VERILATOR ?= verilator
TOP       ?= tb_gbuf_link
FILELIST  ?= gbuf_link_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
